/* src/toy_core_pkg.sv */
package toy_core_pkg;

    // instruction layout, opcode in the top bits
    parameter int INSTR_W   = 16;
    parameter int OP_W      = 2;
    parameter int OPERAND_W = INSTR_W - OP_W;

    // instruction memory is 256 words
    parameter int ADDR_W = 8;

    // fetch target after a retired trap
    parameter logic [ADDR_W-1:0] TRAP_VECTOR = 8'hF0;

    // accumulator instruction set
    typedef enum logic [OP_W-1:0] {
        // acc = acc + operand
        OP_ADD  = 2'b00,
        // acc = 0
        OP_CLR  = 2'b01,
        // jump to operand address when acc is nonzero
        OP_BNZ  = 2'b10,
        // jump to trap vector, cause from operand bit 0
        OP_TRAP = 2'b11
    } opcode_t;

    // reason reported with a pipeline flush
    typedef enum logic [1:0] {
        CAUSE_NONE   = 2'b00,
        CAUSE_BRANCH = 2'b01,
        CAUSE_TRAP_A = 2'b10,
        CAUSE_TRAP_B = 2'b11
    } cause_t;

endpackage

/* src/fetch_stage.sv */
module fetch_stage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               flush,
    input  logic [toy_core_pkg::ADDR_W-1:0]    redirect_pc,
    output logic                               wb_cyc,
    output logic                               wb_stb,
    output logic [toy_core_pkg::ADDR_W-1:0]    wb_adr,
    input  logic                               wb_ack,
    input  logic [toy_core_pkg::INSTR_W-1:0]   wb_dat_i,
    output logic                               if_valid,
    output logic [toy_core_pkg::INSTR_W-1:0]   if_instr,
    output logic [toy_core_pkg::ADDR_W-1:0]    if_pc
);

    // address of the access in flight, held until ack
    logic [toy_core_pkg::ADDR_W-1:0] pc;
    logic                            busy;
    // open cycle was overtaken by a flush, its data is stale
    logic                            drop_resp;
    logic [toy_core_pkg::ADDR_W-1:0] pend_pc;
    logic                            resp;

    assign resp   = busy && wb_ack;
    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_adr = pc;

    // bus master, back to back reads once out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            busy      <= 1'b0;
            drop_resp <= 1'b0;
        end else if (!busy) begin
            busy <= 1'b1;
            if (flush) begin
                pc <= redirect_pc;
            end
        end else if (resp) begin
            drop_resp <= 1'b0;
            if (flush) begin
                pc <= redirect_pc;
            end else if (drop_resp) begin
                pc <= pend_pc;
            end else begin
                pc <= pc + 1'b1;
            end
        end else if (flush) begin
            drop_resp <= 1'b1;
        end
    end

    // redirect parked until the open cycle completes
    always_ff @(posedge clk) begin
        if (busy && !wb_ack && flush) begin
            pend_pc <= redirect_pc;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (rst) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= resp && !flush && !drop_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (resp) begin
            if_instr <= wb_dat_i;
            if_pc    <= pc;
        end
    end

endmodule

/* src/decode_stage.sv */
module decode_stage (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 flush,
    input  logic                                 if_valid,
    input  logic [toy_core_pkg::INSTR_W-1:0]     if_instr,
    input  logic [toy_core_pkg::ADDR_W-1:0]      if_pc,
    output logic                                 id_valid,
    output toy_core_pkg::opcode_t                id_op,
    output logic [toy_core_pkg::OPERAND_W-1:0]   id_operand,
    output logic [toy_core_pkg::ADDR_W-1:0]      id_pc
);

    toy_core_pkg::opcode_t                 dec_op;
    logic [toy_core_pkg::OPERAND_W-1:0]    dec_operand;

    // opcode sits above the operand field
    assign dec_op = toy_core_pkg::opcode_t'(
        if_instr[toy_core_pkg::INSTR_W-1 -: toy_core_pkg::OP_W]);
    assign dec_operand = if_instr[toy_core_pkg::OPERAND_W-1:0];

    // decode/execute register
    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= if_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid) begin
            id_op      <= dec_op;
            id_operand <= dec_operand;
            id_pc      <= if_pc;
        end
    end

endmodule

/* src/execute_stage.sv */
module execute_stage #(
    parameter int DATA_W = 16
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 flush,
    input  logic                                 id_valid,
    input  toy_core_pkg::opcode_t                id_op,
    input  logic [toy_core_pkg::OPERAND_W-1:0]   id_operand,
    input  logic [toy_core_pkg::ADDR_W-1:0]      id_pc,
    input  logic [DATA_W-1:0]                    arch_acc,
    output logic                                 flush_from_ex,
    output logic [toy_core_pkg::ADDR_W-1:0]      redirect_ex_pc,
    output logic                                 ex_valid,
    output toy_core_pkg::opcode_t                ex_op,
    output logic [DATA_W-1:0]                    ex_result,
    output logic [toy_core_pkg::OPERAND_W-1:0]   ex_operand,
    output logic [toy_core_pkg::ADDR_W-1:0]      ex_pc
);

    logic [DATA_W-1:0] fwd_acc;
    logic [DATA_W-1:0] operand_ext;
    logic [DATA_W-1:0] new_acc;

    // older item still waiting in writeback has the newest acc
    assign fwd_acc = (ex_valid && ex_op != toy_core_pkg::OP_TRAP) ? ex_result : arch_acc;

    // zero extended operand
    assign operand_ext = DATA_W'(id_operand);

    always_comb begin
        case (id_op)
            toy_core_pkg::OP_ADD: new_acc = fwd_acc + operand_ext;
            toy_core_pkg::OP_CLR: new_acc = '0;
            default:              new_acc = fwd_acc;
        endcase
    end

    // branch resolves here, target is the low operand bits
    assign flush_from_ex  = id_valid && (id_op == toy_core_pkg::OP_BNZ) && (fwd_acc != '0);
    assign redirect_ex_pc = id_operand[toy_core_pkg::ADDR_W-1:0];

    // execute/writeback register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex_op      <= id_op;
            ex_result  <= new_acc;
            ex_operand <= id_operand;
            ex_pc      <= id_pc;
        end
    end

endmodule

/* src/writeback_stage.sv */
module writeback_stage #(
    parameter int DATA_W = 16
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 ex_valid,
    input  toy_core_pkg::opcode_t                ex_op,
    input  logic [DATA_W-1:0]                    ex_result,
    input  logic [toy_core_pkg::OPERAND_W-1:0]   ex_operand,
    input  logic [toy_core_pkg::ADDR_W-1:0]      ex_pc,
    output logic [DATA_W-1:0]                    arch_acc,
    output logic                                 flush_from_wb,
    output toy_core_pkg::cause_t                 cause_from_wb,
    output logic                                 retire_valid,
    output logic [toy_core_pkg::ADDR_W-1:0]      retire_pc,
    output logic [DATA_W-1:0]                    retire_acc,
    output toy_core_pkg::cause_t                 retire_cause
);

    logic is_trap;

    assign is_trap       = ex_op == toy_core_pkg::OP_TRAP;
    assign flush_from_wb = ex_valid && is_trap;

    // trap cause picked by operand bit 0
    assign cause_from_wb = !flush_from_wb ? toy_core_pkg::CAUSE_NONE :
                           ex_operand[0]  ? toy_core_pkg::CAUSE_TRAP_B :
                                            toy_core_pkg::CAUSE_TRAP_A;

    // architectural accumulator, traps leave it alone
    always_ff @(posedge clk) begin
        if (rst) begin
            arch_acc <= '0;
        end else if (ex_valid && !is_trap) begin
            arch_acc <= ex_result;
        end
    end

    // retire port, one cycle behind commit
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_pc    <= '0;
            retire_acc   <= '0;
            retire_cause <= toy_core_pkg::CAUSE_NONE;
        end else begin
            retire_valid <= ex_valid;
            if (ex_valid) begin
                retire_pc    <= ex_pc;
                retire_acc   <= is_trap ? arch_acc : ex_result;
                retire_cause <= cause_from_wb;
            end
        end
    end

endmodule

/* src/hazard_unit.sv */
module hazard_unit (
    input  logic                               flush_from_wb,
    input  logic                               flush_from_ex,
    input  toy_core_pkg::cause_t               cause_from_wb,
    input  logic [toy_core_pkg::ADDR_W-1:0]    redirect_ex_pc,
    output logic                               flush_to_fetch,
    output logic                               flush_to_if_id,
    output logic                               flush_to_id_ex,
    output logic                               flush_to_ex_wb,
    output logic [toy_core_pkg::ADDR_W-1:0]    redirect_pc,
    output toy_core_pkg::cause_t               flush_cause
);

    // writeback is the oldest source and wins over execute
    assign flush_cause    = flush_from_wb ? cause_from_wb :
                            flush_from_ex ? toy_core_pkg::CAUSE_BRANCH :
                                            toy_core_pkg::CAUSE_NONE;

    assign redirect_pc    = flush_from_wb ? toy_core_pkg::TRAP_VECTOR : redirect_ex_pc;

    // only a trap kills the item leaving execute
    assign flush_to_ex_wb = flush_from_wb ? 1'b1 : 1'b0;

    assign flush_to_id_ex = flush_from_wb ? 1'b1 :
                            flush_from_ex ? 1'b1 : 1'b0;

    assign flush_to_if_id = flush_from_wb ? 1'b1 :
                            flush_from_ex ? 1'b1 : 1'b0;

    // pc follows the same sources as the front register
    assign flush_to_fetch = flush_to_if_id;

endmodule

/* src/toy_core.sv */
module toy_core #(
    parameter int DATA_W = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    output logic                               wb_cyc,
    output logic                               wb_stb,
    output logic [toy_core_pkg::ADDR_W-1:0]    wb_adr,
    input  logic                               wb_ack,
    input  logic [toy_core_pkg::INSTR_W-1:0]   wb_dat_i,
    output logic                               retire_valid,
    output logic [toy_core_pkg::ADDR_W-1:0]    retire_pc,
    output logic [DATA_W-1:0]                  retire_acc,
    output toy_core_pkg::cause_t               retire_cause,
    output toy_core_pkg::cause_t               flush_cause
);

    logic                                if_valid;
    logic [toy_core_pkg::INSTR_W-1:0]    if_instr;
    logic [toy_core_pkg::ADDR_W-1:0]     if_pc;

    logic                                id_valid;
    toy_core_pkg::opcode_t               id_op;
    logic [toy_core_pkg::OPERAND_W-1:0]  id_operand;
    logic [toy_core_pkg::ADDR_W-1:0]     id_pc;

    logic                                ex_valid;
    toy_core_pkg::opcode_t               ex_op;
    logic [DATA_W-1:0]                   ex_result;
    logic [toy_core_pkg::OPERAND_W-1:0]  ex_operand;
    logic [toy_core_pkg::ADDR_W-1:0]     ex_pc;

    logic [DATA_W-1:0]                   arch_acc;
    logic                                flush_from_ex;
    logic [toy_core_pkg::ADDR_W-1:0]     redirect_ex_pc;
    logic                                flush_from_wb;
    toy_core_pkg::cause_t                cause_from_wb;

    logic                                flush_to_fetch;
    logic                                flush_to_if_id;
    logic                                flush_to_id_ex;
    logic                                flush_to_ex_wb;
    logic [toy_core_pkg::ADDR_W-1:0]     redirect_pc;

    // pc and fetch/decode register sit behind one flush input
    fetch_stage u_fetch (
        .clk(clk), .rst(rst), .flush(flush_to_fetch | flush_to_if_id),
        .redirect_pc(redirect_pc), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_ack(wb_ack), .wb_dat_i(wb_dat_i),
        .if_valid(if_valid), .if_instr(if_instr), .if_pc(if_pc)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .flush(flush_to_id_ex),
        .if_valid(if_valid), .if_instr(if_instr), .if_pc(if_pc),
        .id_valid(id_valid), .id_op(id_op), .id_operand(id_operand), .id_pc(id_pc)
    );

    execute_stage #(.DATA_W(DATA_W)) u_execute (
        .clk(clk), .rst(rst), .flush(flush_to_ex_wb),
        .id_valid(id_valid), .id_op(id_op), .id_operand(id_operand), .id_pc(id_pc),
        .arch_acc(arch_acc), .flush_from_ex(flush_from_ex), .redirect_ex_pc(redirect_ex_pc),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_result(ex_result),
        .ex_operand(ex_operand), .ex_pc(ex_pc)
    );

    writeback_stage #(.DATA_W(DATA_W)) u_writeback (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_result(ex_result),
        .ex_operand(ex_operand), .ex_pc(ex_pc),
        .arch_acc(arch_acc), .flush_from_wb(flush_from_wb), .cause_from_wb(cause_from_wb),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_acc(retire_acc), .retire_cause(retire_cause)
    );

    hazard_unit u_hazard (
        .flush_from_wb(flush_from_wb), .flush_from_ex(flush_from_ex),
        .cause_from_wb(cause_from_wb), .redirect_ex_pc(redirect_ex_pc),
        .flush_to_fetch(flush_to_fetch), .flush_to_if_id(flush_to_if_id),
        .flush_to_id_ex(flush_to_id_ex), .flush_to_ex_wb(flush_to_ex_wb),
        .redirect_pc(redirect_pc), .flush_cause(flush_cause)
    );

endmodule

/* verification/toy_core_checker.sv */
module toy_core_checker #(
    parameter int DATA_W = 16
) (
    input logic                               clk,
    input logic                               rst,
    input logic                               wb_cyc,
    input logic                               wb_stb,
    input logic [toy_core_pkg::ADDR_W-1:0]    wb_adr,
    input logic                               wb_ack,
    input logic                               flush_from_wb,
    input logic                               flush_from_ex,
    input toy_core_pkg::cause_t               flush_cause,
    input logic                               retire_valid,
    input logic [toy_core_pkg::ADDR_W-1:0]    retire_pc,
    input logic [DATA_W-1:0]                  retire_acc,
    input toy_core_pkg::cause_t               retire_cause
);

    // number of failed properties
    int failures;

    initial failures = 0;

    stb_within_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else begin
            failures++;
            $error("wb_stb high outside a bus cycle");
        end

    // request held until the slave answers
    req_stable: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr))
        else begin
            failures++;
            $error("bus request changed before ack");
        end

    cause_needs_flush: assert property (@(posedge clk) disable iff (rst)
        !(flush_from_wb || flush_from_ex) |-> flush_cause == toy_core_pkg::CAUSE_NONE)
        else begin
            failures++;
            $error("flush_cause set with no flush active");
        end

    known_outputs: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({wb_cyc, wb_stb, wb_adr, retire_valid, retire_pc, retire_acc,
                     retire_cause, flush_cause}))
        else begin
            failures++;
            $error("core output unknown after reset");
        end

endmodule

bind toy_core toy_core_checker #(.DATA_W(DATA_W)) u_checker (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_ack(wb_ack),
    .flush_from_wb(flush_from_wb), .flush_from_ex(flush_from_ex),
    .flush_cause(flush_cause), .retire_valid(retire_valid),
    .retire_pc(retire_pc), .retire_acc(retire_acc), .retire_cause(retire_cause)
);

/* verification/toy_core_tb.sv */
module toy_core_tb;

    localparam int DATA_W     = 16;
    localparam int NUM_RETIRE = 300;
    localparam int TIMEOUT    = 64;
    localparam int WAIT_TAB   = 4096;
    localparam int NUM_TESTS  = 6;

    localparam int T_RESET  = 0;
    localparam int T_ARITH  = 1;
    localparam int T_BRANCH = 2;
    localparam int T_TRAP   = 3;
    localparam int T_CAUSE  = 4;
    localparam int T_LONG   = 5;

    logic                                clk;
    logic                                rst;
    logic                                wb_cyc;
    logic                                wb_stb;
    logic [toy_core_pkg::ADDR_W-1:0]     wb_adr;
    logic                                wb_ack;
    logic [toy_core_pkg::INSTR_W-1:0]    wb_dat_i;
    logic                                retire_valid;
    logic [toy_core_pkg::ADDR_W-1:0]     retire_pc;
    logic [DATA_W-1:0]                   retire_acc;
    toy_core_pkg::cause_t                retire_cause;
    toy_core_pkg::cause_t                flush_cause;

    logic [toy_core_pkg::INSTR_W-1:0]    imem [0:255];
    // wait states per bus access drawn up front
    int unsigned                         wait_tab [0:WAIT_TAB-1];
    int                                  wait_idx;
    int unsigned                         waits_left;
    logic                                in_access;

    // reference model state
    logic [toy_core_pkg::ADDR_W-1:0]     m_pc;
    logic [DATA_W-1:0]                   m_acc;

    // flush causes seen on the port in arrival order
    toy_core_pkg::cause_t                cause_q [$];

    string                               names [NUM_TESTS];
    int                                  checks [NUM_TESTS];
    int                                  errors [NUM_TESTS];

    toy_core #(.DATA_W(DATA_W)) UUT (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_ack(wb_ack), .wb_dat_i(wb_dat_i),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_acc(retire_acc), .retire_cause(retire_cause),
        .flush_cause(flush_cause)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // wishbone slave with 0 to 3 wait cycles per access
    initial begin
        wb_ack     = 1'b0;
        wb_dat_i   = '0;
        in_access  = 1'b0;
        waits_left = 0;
        wait_idx   = 0;
        forever begin
            @(negedge clk);
            if (wb_cyc && wb_stb) begin
                if (!in_access) begin
                    waits_left = wait_tab[wait_idx];
                    wait_idx   = (wait_idx + 1) % WAIT_TAB;
                    in_access  = 1'b1;
                end
                if (waits_left == 0) begin
                    wb_ack    = 1'b1;
                    wb_dat_i  = imem[wb_adr];
                    in_access = 1'b0;
                end else begin
                    wb_ack     = 1'b0;
                    waits_left = waits_left - 1;
                end
            end else begin
                wb_ack    = 1'b0;
                in_access = 1'b0;
            end
        end
    end

    function automatic logic [toy_core_pkg::INSTR_W-1:0] random_instr();
        int unsigned                         pick;
        logic [31:0]                         bits;
        toy_core_pkg::opcode_t               op;
        pick = $urandom % 100;
        bits = $urandom;
        if (pick < 50) begin
            op = toy_core_pkg::OP_ADD;
        end else if (pick < 65) begin
            op = toy_core_pkg::OP_CLR;
        end else if (pick < 85) begin
            op = toy_core_pkg::OP_BNZ;
        end else begin
            op = toy_core_pkg::OP_TRAP;
        end
        return {op, bits[toy_core_pkg::OPERAND_W-1:0]};
    endfunction

    task automatic check_val(input int test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
        checks[test]++;
        assert (expected == actual) else begin
            errors[test]++;
            $display("Error %s %s: expected %0h, actual %0h",
                     names[test], what, expected, actual);
        end
    endtask

    task automatic check_true(input int test, input bit ok, input string msg);
        checks[test]++;
        assert (ok) else begin
            errors[test]++;
            $display("%s: %s", names[test], msg);
        end
    endtask

    task automatic sample_flush();
        if (flush_cause != toy_core_pkg::CAUSE_NONE) begin
            cause_q.push_back(flush_cause);
        end
    endtask

    task automatic wait_retire(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            sample_flush();
            seen = retire_valid;
            cycles++;
        end
    endtask

    // one instruction in program order with its redirect reason
    task automatic model_step(output toy_core_pkg::opcode_t op,
                              output logic [toy_core_pkg::ADDR_W-1:0] pc,
                              output logic [DATA_W-1:0] acc,
                              output toy_core_pkg::cause_t cause);
        logic [toy_core_pkg::INSTR_W-1:0]    instr;
        logic [toy_core_pkg::OPERAND_W-1:0]  operand;
        instr   = imem[m_pc];
        operand = instr[toy_core_pkg::OPERAND_W-1:0];
        op      = toy_core_pkg::opcode_t'(instr[toy_core_pkg::INSTR_W-1 -: toy_core_pkg::OP_W]);
        pc      = m_pc;
        cause   = toy_core_pkg::CAUSE_NONE;
        m_pc    = m_pc + 1'b1;
        case (op)
            toy_core_pkg::OP_ADD: m_acc = m_acc + DATA_W'(operand);
            toy_core_pkg::OP_CLR: m_acc = '0;
            toy_core_pkg::OP_BNZ: begin
                if (m_acc != '0) begin
                    m_pc  = operand[toy_core_pkg::ADDR_W-1:0];
                    cause = toy_core_pkg::CAUSE_BRANCH;
                end
            end
            default: begin
                m_pc  = toy_core_pkg::TRAP_VECTOR;
                cause = operand[0] ? toy_core_pkg::CAUSE_TRAP_B : toy_core_pkg::CAUSE_TRAP_A;
            end
        endcase
        acc = m_acc;
    endtask

    task automatic report_test(input int test);
        $display("test %s: %0d checks, %0d errors, %s", names[test], checks[test],
                 errors[test], (errors[test] == 0) ? "passed" : "failed");
    endtask

    initial begin
        int                                  n;
        int                                  t;
        int                                  cycles;
        bit                                  seen;
        bit                                  timed_out;
        bit                                  trap_next;
        bit                                  redirect_next;
        logic [toy_core_pkg::ADDR_W-1:0]     redirect_target;
        toy_core_pkg::opcode_t               op;
        logic [toy_core_pkg::ADDR_W-1:0]     exp_pc;
        logic [DATA_W-1:0]                   exp_acc;
        logic [DATA_W-1:0]                   prev_acc;
        toy_core_pkg::cause_t                exp_cause;
        toy_core_pkg::cause_t                ret_cause;
        int                                  total_checks;
        int                                  total_errors;
        int                                  tests_failed;
        int                                  assert_fails;

        rst = 1'b1;
        void'($urandom(72));
        names[T_RESET]  = "reset_state";
        names[T_ARITH]  = "arith_stream";
        names[T_BRANCH] = "branches";
        names[T_TRAP]   = "traps";
        names[T_CAUSE]  = "flush_cause";
        names[T_LONG]   = "long_run";
        for (t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        // trap vector region gets random code as well
        for (n = 0; n < 256; n++) begin
            imem[n] = random_instr();
        end
        for (n = 0; n < WAIT_TAB; n++) begin
            wait_tab[n] = $urandom % 4;
        end
        m_pc          = '0;
        m_acc         = '0;
        timed_out     = 1'b0;
        trap_next     = 1'b0;
        redirect_next = 1'b0;

        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_val(T_RESET, "wb_cyc", 32'd0, 32'(wb_cyc));
        check_val(T_RESET, "retire_valid", 32'd0, 32'(retire_valid));
        cycles = 0;
        while (!wb_cyc && cycles < TIMEOUT) begin
            @(negedge clk);
            sample_flush();
            cycles++;
        end
        if (!wb_cyc) begin
            timed_out = 1'b1;
            errors[T_RESET]++;
            $display("timeout: no bus cycle started within %0d cycles of reset", TIMEOUT);
        end else begin
            check_val(T_RESET, "first wb_adr", 32'd0, 32'(wb_adr));
        end
        report_test(T_RESET);

        n = 0;
        while (n < NUM_RETIRE && !timed_out) begin
            wait_retire(seen);
            if (!seen) begin
                timed_out = 1'b1;
                errors[T_LONG]++;
                $display("timeout: retirement %0d did not appear within %0d cycles",
                         n, TIMEOUT);
            end else begin
                prev_acc = m_acc;
                model_step(op, exp_pc, exp_acc, exp_cause);
                ret_cause = (exp_cause == toy_core_pkg::CAUSE_BRANCH) ?
                            toy_core_pkg::CAUSE_NONE : exp_cause;

                // a squashed item breaks program order here
                check_val(T_BRANCH, "retire_pc", 32'(exp_pc), 32'(retire_pc));
                if (trap_next) begin
                    check_val(T_TRAP, "pc after trap", 32'(toy_core_pkg::TRAP_VECTOR),
                              32'(retire_pc));
                end
                if (redirect_next) begin
                    check_val(T_CAUSE, "pc after flush", 32'(redirect_target),
                              32'(retire_pc));
                end
                trap_next     = 1'b0;
                redirect_next = 1'b0;

                if (op == toy_core_pkg::OP_ADD || op == toy_core_pkg::OP_CLR) begin
                    check_val(T_ARITH, "retire_acc", 32'(exp_acc), 32'(retire_acc));
                end
                if (op == toy_core_pkg::OP_TRAP) begin
                    check_val(T_TRAP, "retire_cause", 32'(exp_cause), 32'(retire_cause));
                    check_val(T_TRAP, "acc across trap", 32'(prev_acc), 32'(retire_acc));
                    trap_next = 1'b1;
                end

                // every redirect must have shown its cause on the port
                if (exp_cause != toy_core_pkg::CAUSE_NONE) begin
                    if (cause_q.size() == 0) begin
                        check_true(T_CAUSE, 1'b0, $sformatf(
                            "redirect at pc %0h retired with no flush cause seen", exp_pc));
                    end else begin
                        check_val(T_CAUSE, "flush_cause", 32'(exp_cause),
                                  32'(cause_q.pop_front()));
                    end
                    redirect_next   = 1'b1;
                    redirect_target = m_pc;
                end

                check_val(T_LONG, "retirement", 32'({exp_pc, exp_acc, ret_cause}),
                          32'({retire_pc, retire_acc, retire_cause}));
                n++;
            end
        end

        for (t = 1; t < NUM_TESTS; t++) begin
            report_test(t);
        end
        total_checks = 0;
        total_errors = 0;
        tests_failed = 0;
        for (t = 0; t < NUM_TESTS; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
            if (errors[t] != 0) begin
                tests_failed++;
            end
        end
        assert_fails = UUT.u_checker.failures;
        $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d, asserts failed: %0d",
                 NUM_TESTS - tests_failed, tests_failed, total_checks, total_errors,
                 assert_fails);
        if (timed_out || total_errors != 0 || assert_fails != 0) begin
            $display("** FAIL **");
        end else begin
            $display("** PASS **");
        end
        $finish;
    end

endmodule

/* toy_core.f */
src/toy_core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/writeback_stage.sv
src/hazard_unit.sv
src/toy_core.sv
verification/toy_core_checker.sv
verification/toy_core_tb.sv

/* Makefile */
TOP := toy_core_tb
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): toy_core.f $(wildcard src/*.sv verification/*.sv)
	verilator --binary --assert -j 0 --top-module $(TOP) -f toy_core.f

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 > sim.log 2>&1; rc=$$?; cat sim.log; test $$rc -eq 0
	@if grep -qF '** FAIL **' sim.log; then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
